// ==== dir_pkg.sv ====
/* coherence directory shared definitions
   widths, entry and row layout, command and state encodings, request bundle */

`default_nettype none

package dir_pkg;

  // address layout
  localparam int paddr_width_c = 32;
  localparam int block_offset_c = 6;
  localparam int set_bits_c = 6;
  localparam int tag_offset_c = block_offset_c + set_bits_c;
  localparam int tag_width_c = paddr_width_c - tag_offset_c;

  // directory geometry
  localparam int assoc_c = 8;
  localparam int way_width_c = $clog2(assoc_c);
  // even lce in tag set 0, odd lce in tag set 1
  localparam int tag_sets_per_row_c = 2;
  localparam int lce_width_c = 8;

  typedef logic [paddr_width_c-1:0] paddr_t;
  typedef logic [tag_width_c-1:0] tag_t;
  typedef logic [way_width_c-1:0] way_t;
  typedef logic [lce_width_c-1:0] lce_t;

  // any non-zero state counts as valid
  typedef enum logic [2:0] {
    COH_I = 3'd0,
    COH_S,
    COH_E,
    COH_F,
    COH_O,
    COH_M
  } coh_state_e;

  typedef enum logic [2:0] {
    CMD_RDW,
    CMD_RDE,
    CMD_WDE,
    CMD_WDS,
    CMD_CLR
  } dir_cmd_e;

  // one way of one tag set
  typedef struct packed {
    tag_t tag;
    coh_state_e state;
  } dir_entry_t;

  typedef dir_entry_t [assoc_c-1:0] dir_tag_set_t;
  typedef dir_tag_set_t [tag_sets_per_row_c-1:0] dir_row_t;

  // request as seen at the segment boundary
  typedef struct packed {
    dir_cmd_e cmd;
    lce_t lce;
    way_t way;
    paddr_t addr;
    coh_state_e state;
  } dir_req_t;

endpackage

`default_nettype wire

// ==== dir_ram.sv ====
/* directory row memory
   single port, synchronous read, bit-masked write */

`default_nettype none

module dir_ram #(
  parameter int rows_p = 128,
  localparam int addr_width_lp = (rows_p > 1) ? $clog2(rows_p) : 1
) (
  input  wire                       clk_i,
  input  wire                       en_i,
  input  wire                       we_i,
  input  wire [addr_width_lp-1:0]   addr_i,
  input  dir_pkg::dir_row_t         mask_i,
  input  dir_pkg::dir_row_t         wdata_i,
  output dir_pkg::dir_row_t         rdata_o
);

  dir_pkg::dir_row_t mem_r [rows_p];

  // only masked bits take the new value
  always_ff @(posedge clk_i) begin
    if (en_i && we_i) begin
      mem_r[addr_i] <= (mem_r[addr_i] & ~mask_i) | (wdata_i & mask_i);
    end
  end

  // read data valid the cycle after the access
  // output holds across writes and idle cycles
  always_ff @(posedge clk_i) begin
    if (en_i && !we_i) begin
      rdata_o <= mem_r[addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== dir_tag_check.sv ====
/* directory tag checker
   per tag set, lowest hitting way and its state for the row on the ram output */

`default_nettype none

module dir_tag_check (
  input  dir_pkg::dir_row_t                                    row_i,
  input  wire [dir_pkg::tag_sets_per_row_c-1:0]                row_v_i,
  input  dir_pkg::tag_t                                        tag_i,
  output logic [dir_pkg::tag_sets_per_row_c-1:0]               hits_o,
  output dir_pkg::way_t [dir_pkg::tag_sets_per_row_c-1:0]      ways_o,
  output dir_pkg::coh_state_e [dir_pkg::tag_sets_per_row_c-1:0] states_o
);

  always_comb begin
    for (int t = 0; t < dir_pkg::tag_sets_per_row_c; t++) begin
      // no hit reports way 0 in state I
      hits_o[t] = 1'b0;
      ways_o[t] = '0;
      states_o[t] = dir_pkg::COH_I;
      // scan from the top so the lowest match is the one that stays
      for (int w = dir_pkg::assoc_c - 1; w >= 0; w--) begin
        if (row_v_i[t] && (row_i[t][w].tag == tag_i) &&
            (row_i[t][w].state != dir_pkg::COH_I)) begin
          hits_o[t] = 1'b1;
          ways_o[t] = dir_pkg::way_t'(w);
          states_o[t] = row_i[t][w].state;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== dir_sharers.sv ====
/* sharers vector and entry address registers
   collect per-lce hit, way and state from full reads, or one entry from an entry read */

`default_nettype none

module dir_sharers #(
  parameter int num_lce_p = 4,
  localparam int rows_per_set_lp =
    (num_lce_p + dir_pkg::tag_sets_per_row_c - 1) / dir_pkg::tag_sets_per_row_c,
  localparam int row_num_width_lp = (rows_per_set_lp > 1) ? $clog2(rows_per_set_lp) : 1
) (
  input  wire                                                   clk_i,
  input  wire                                                   reset_i,
  input  wire                                                   clear_i,
  input  wire                                                   capture_row_i,
  input  wire [row_num_width_lp-1:0]                            row_num_i,
  input  wire                                                   capture_entry_i,
  input  wire                                                   done_i,
  input  wire [dir_pkg::tag_sets_per_row_c-1:0]                 hits_i,
  input  dir_pkg::way_t [dir_pkg::tag_sets_per_row_c-1:0]       ways_i,
  input  dir_pkg::coh_state_e [dir_pkg::tag_sets_per_row_c-1:0] states_i,
  input  dir_pkg::dir_row_t                                     row_i,
  input  dir_pkg::lce_t                                         lce_i,
  input  dir_pkg::way_t                                         way_i,
  input  dir_pkg::tag_t                                         tag_i,
  output logic                                                  sharers_v_o,
  output logic [num_lce_p-1:0]                                  sharers_hits_o,
  output dir_pkg::way_t [num_lce_p-1:0]                         sharers_ways_o,
  output dir_pkg::coh_state_e [num_lce_p-1:0]                   sharers_states_o,
  output logic                                                  addr_v_o,
  output dir_pkg::paddr_t                                       addr_o
);

  // addressed entry of an entry read
  dir_pkg::dir_entry_t entry;

  assign entry = row_i[lce_i[0]][way_i];

  // valid flags drop on any accepted request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sharers_v_o <= 1'b0;
      addr_v_o <= 1'b0;
    end else if (clear_i) begin
      sharers_v_o <= 1'b0;
      addr_v_o <= 1'b0;
    end else begin
      if (done_i) begin
        sharers_v_o <= 1'b1;
      end
      if (capture_entry_i) begin
        addr_v_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      sharers_hits_o <= '0;
      sharers_ways_o <= '0;
      for (int s = 0; s < num_lce_p; s++) begin
        sharers_states_o[s] <= dir_pkg::COH_I;
      end
    end else if (capture_row_i) begin
      // slot s lives in row s/2, tag set s%2
      for (int s = 0; s < num_lce_p; s++) begin
        if (row_num_i == row_num_width_lp'(s / dir_pkg::tag_sets_per_row_c)) begin
          sharers_hits_o[s] <= hits_i[s % dir_pkg::tag_sets_per_row_c];
          sharers_ways_o[s] <= ways_i[s % dir_pkg::tag_sets_per_row_c];
          sharers_states_o[s] <= states_i[s % dir_pkg::tag_sets_per_row_c];
        end
      end
    end else if (capture_entry_i) begin
      // entry result goes to slot 0, other slots stay cleared
      sharers_hits_o[0] <= (entry.tag == tag_i) && (entry.state != dir_pkg::COH_I);
      sharers_ways_o[0] <= way_i;
      sharers_states_o[0] <= entry.state;
    end
  end

  // stored tag with set and offset bits zero
  always_ff @(posedge clk_i) begin
    if (capture_entry_i) begin
      addr_o <= {entry.tag, {dir_pkg::tag_offset_c{1'b0}}};
    end
  end

endmodule

`default_nettype wire

// ==== dir_ctrl.sv ====
/* directory sequencing FSM
   clears rows after reset, decodes requests, steps through the rows of a full read */

`default_nettype none

module dir_ctrl #(
  parameter int num_lce_p = 4,
  parameter int tag_sets_p = 64,
  localparam int rows_per_set_lp =
    (num_lce_p + dir_pkg::tag_sets_per_row_c - 1) / dir_pkg::tag_sets_per_row_c,
  localparam int rows_lp = rows_per_set_lp * tag_sets_p,
  localparam int row_addr_width_lp = (rows_lp > 1) ? $clog2(rows_lp) : 1,
  localparam int row_num_width_lp = (rows_per_set_lp > 1) ? $clog2(rows_per_set_lp) : 1
) (
  input  wire                                          clk_i,
  input  wire                                          reset_i,
  input  wire                                          req_v_i,
  input  dir_pkg::dir_req_t                            req_i,
  output logic                                         busy_o,
  output logic                                         ram_en_o,
  output logic                                         ram_we_o,
  output logic [row_addr_width_lp-1:0]                 ram_addr_o,
  output dir_pkg::dir_row_t                            ram_mask_o,
  output dir_pkg::dir_row_t                            ram_wdata_o,
  output logic [dir_pkg::tag_sets_per_row_c-1:0]       row_v_o,
  output dir_pkg::tag_t                                tag_o,
  output dir_pkg::lce_t                                lce_o,
  output dir_pkg::way_t                                way_o,
  output logic                                         clear_o,
  output logic                                         capture_row_o,
  output logic [row_num_width_lp-1:0]                  row_num_o,
  output logic                                         capture_entry_o,
  output logic                                         done_o
);

  typedef enum logic [2:0] {
    RESET,
    INIT,
    READY,
    READ_FULL,
    READ_ENTRY
  } ctrl_state_e;

  ctrl_state_e state_r, state_n;
  logic [row_addr_width_lp-1:0] cnt_r, cnt_n;
  logic [row_addr_width_lp-1:0] addr_r, addr_n;
  logic [dir_pkg::tag_sets_per_row_c-1:0] row_v_r, row_v_n;
  dir_pkg::dir_req_t req_r;
  logic req_capture;

  // row of the set for lce 0 and 1, and the row holding the addressed lce
  logic [row_addr_width_lp-1:0] set_row;
  logic [row_addr_width_lp-1:0] entry_row;

  // tag sets holding real lces in row k of a set
  function automatic logic [dir_pkg::tag_sets_per_row_c-1:0] row_mask(input int k);
    row_mask = ((2 * k + 1) < num_lce_p) ? 2'b11 : 2'b01;
  endfunction

  // set index is the low set bits modulo the sets stored
  assign set_row = row_addr_width_lp'(
    req_i.addr[dir_pkg::block_offset_c +: dir_pkg::set_bits_c] % tag_sets_p);
  assign entry_row = row_addr_width_lp'((req_i.lce >> 1) * tag_sets_p) + set_row;

  assign busy_o = (state_r != READY);
  assign row_v_o = row_v_r;
  assign tag_o = req_r.addr[dir_pkg::tag_offset_c +: dir_pkg::tag_width_c];
  assign lce_o = req_r.lce;
  assign way_o = req_r.way;
  assign row_num_o = cnt_r[row_num_width_lp-1:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= RESET;
      cnt_r <= '0;
      addr_r <= '0;
      row_v_r <= '0;
    end else begin
      state_r <= state_n;
      cnt_r <= cnt_n;
      addr_r <= addr_n;
      row_v_r <= row_v_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_capture) begin
      req_r <= req_i;
    end
  end

  always_comb begin
    state_n = state_r;
    cnt_n = cnt_r;
    addr_n = addr_r;
    // row valid only for the cycle after a full read access
    row_v_n = '0;
    req_capture = 1'b0;
    ram_en_o = 1'b0;
    ram_we_o = 1'b0;
    ram_addr_o = '0;
    ram_mask_o = '0;
    ram_wdata_o = '0;
    clear_o = 1'b0;
    capture_row_o = 1'b0;
    capture_entry_o = 1'b0;
    done_o = 1'b0;

    case (state_r)
      RESET: begin
        cnt_n = '0;
        state_n = INIT;
      end
      INIT: begin
        // one clearing write per row
        ram_en_o = 1'b1;
        ram_we_o = 1'b1;
        ram_addr_o = cnt_r;
        ram_mask_o = '1;
        if (cnt_r == row_addr_width_lp'(rows_lp - 1)) begin
          cnt_n = '0;
          state_n = READY;
        end else begin
          cnt_n = cnt_r + 1'b1;
        end
      end
      READY: begin
        if (req_v_i) begin
          req_capture = 1'b1;
          clear_o = 1'b1;
          cnt_n = '0;
          ram_en_o = 1'b1;
          ram_addr_o = entry_row;
          case (req_i.cmd)
            dir_pkg::CMD_RDW: begin
              // first row of the set, later rows are tag_sets_p apart
              ram_addr_o = set_row;
              addr_n = set_row + row_addr_width_lp'(tag_sets_p);
              row_v_n = row_mask(0);
              state_n = READ_FULL;
            end
            dir_pkg::CMD_RDE: begin
              state_n = READ_ENTRY;
            end
            dir_pkg::CMD_WDE: begin
              ram_we_o = 1'b1;
              ram_mask_o[req_i.lce[0]][req_i.way] = '1;
              ram_wdata_o[req_i.lce[0]][req_i.way].tag =
                req_i.addr[dir_pkg::tag_offset_c +: dir_pkg::tag_width_c];
              ram_wdata_o[req_i.lce[0]][req_i.way].state = req_i.state;
            end
            dir_pkg::CMD_WDS: begin
              // state bits only, tag untouched
              ram_we_o = 1'b1;
              ram_mask_o[req_i.lce[0]][req_i.way].state = dir_pkg::coh_state_e'(3'b111);
              ram_wdata_o[req_i.lce[0]][req_i.way].state = req_i.state;
            end
            dir_pkg::CMD_CLR: begin
              // both tag sets of the row
              ram_we_o = 1'b1;
              ram_mask_o = '1;
            end
            default: begin
              ram_en_o = 1'b0;
            end
          endcase
        end
      end
      READ_FULL: begin
        // fold the row that just came back
        capture_row_o = 1'b1;
        if (cnt_r < row_addr_width_lp'(rows_per_set_lp - 1)) begin
          ram_en_o = 1'b1;
          ram_addr_o = addr_r;
          addr_n = addr_r + row_addr_width_lp'(tag_sets_p);
          row_v_n = row_mask(int'(cnt_r) + 1);
          cnt_n = cnt_r + 1'b1;
        end else begin
          done_o = 1'b1;
          state_n = READY;
        end
      end
      READ_ENTRY: begin
        capture_entry_o = 1'b1;
        done_o = 1'b1;
        state_n = READY;
      end
      default: begin
        state_n = RESET;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== dir_segment.sv ====
/* coherence directory segment top
   ties the sequencing controller to the row memory, tag checker and sharers registers */

`default_nettype none

module dir_segment #(
  parameter int num_lce_p = 4,
  parameter int tag_sets_p = 64,
  localparam int rows_per_set_lp =
    (num_lce_p + dir_pkg::tag_sets_per_row_c - 1) / dir_pkg::tag_sets_per_row_c,
  localparam int rows_lp = rows_per_set_lp * tag_sets_p,
  localparam int row_addr_width_lp = (rows_lp > 1) ? $clog2(rows_lp) : 1,
  localparam int row_num_width_lp = (rows_per_set_lp > 1) ? $clog2(rows_per_set_lp) : 1
) (
  input  wire                                       clk_i,
  input  wire                                       reset_i,
  input  wire                                       req_v_i,
  input  dir_pkg::dir_req_t                         req_i,
  output logic                                      busy_o,
  output logic                                      sharers_v_o,
  output logic [num_lce_p-1:0]                      sharers_hits_o,
  output dir_pkg::way_t [num_lce_p-1:0]             sharers_ways_o,
  output dir_pkg::coh_state_e [num_lce_p-1:0]       sharers_states_o,
  output logic                                      addr_v_o,
  output dir_pkg::paddr_t                           addr_o
);

  // ram port
  logic ram_en;
  logic ram_we;
  logic [row_addr_width_lp-1:0] ram_addr;
  dir_pkg::dir_row_t ram_mask;
  dir_pkg::dir_row_t ram_wdata;
  dir_pkg::dir_row_t rd_row;

  // per tag set check results
  logic [dir_pkg::tag_sets_per_row_c-1:0] row_v;
  logic [dir_pkg::tag_sets_per_row_c-1:0] tc_hits;
  dir_pkg::way_t [dir_pkg::tag_sets_per_row_c-1:0] tc_ways;
  dir_pkg::coh_state_e [dir_pkg::tag_sets_per_row_c-1:0] tc_states;

  // captured request and sharers controls
  dir_pkg::tag_t req_tag;
  dir_pkg::lce_t req_lce;
  dir_pkg::way_t req_way;
  logic clear;
  logic capture_row;
  logic [row_num_width_lp-1:0] row_num;
  logic capture_entry;
  logic done;

  dir_ctrl #(
    .num_lce_p (num_lce_p),
    .tag_sets_p(tag_sets_p)
  ) u_dir_ctrl (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_v_i        (req_v_i),
    .req_i          (req_i),
    .busy_o         (busy_o),
    .ram_en_o       (ram_en),
    .ram_we_o       (ram_we),
    .ram_addr_o     (ram_addr),
    .ram_mask_o     (ram_mask),
    .ram_wdata_o    (ram_wdata),
    .row_v_o        (row_v),
    .tag_o          (req_tag),
    .lce_o          (req_lce),
    .way_o          (req_way),
    .clear_o        (clear),
    .capture_row_o  (capture_row),
    .row_num_o      (row_num),
    .capture_entry_o(capture_entry),
    .done_o         (done)
  );

  dir_ram #(
    .rows_p(rows_lp)
  ) u_dir_ram (
    .clk_i  (clk_i),
    .en_i   (ram_en),
    .we_i   (ram_we),
    .addr_i (ram_addr),
    .mask_i (ram_mask),
    .wdata_i(ram_wdata),
    .rdata_o(rd_row)
  );

  dir_tag_check u_dir_tag_check (
    .row_i   (rd_row),
    .row_v_i (row_v),
    .tag_i   (req_tag),
    .hits_o  (tc_hits),
    .ways_o  (tc_ways),
    .states_o(tc_states)
  );

  dir_sharers #(
    .num_lce_p(num_lce_p)
  ) u_dir_sharers (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .clear_i         (clear),
    .capture_row_i   (capture_row),
    .row_num_i       (row_num),
    .capture_entry_i (capture_entry),
    .done_i          (done),
    .hits_i          (tc_hits),
    .ways_i          (tc_ways),
    .states_i        (tc_states),
    .row_i           (rd_row),
    .lce_i           (req_lce),
    .way_i           (req_way),
    .tag_i           (req_tag),
    .sharers_v_o     (sharers_v_o),
    .sharers_hits_o  (sharers_hits_o),
    .sharers_ways_o  (sharers_ways_o),
    .sharers_states_o(sharers_states_o),
    .addr_v_o        (addr_v_o),
    .addr_o          (addr_o)
  );

endmodule

`default_nettype wire

// ==== dir_clk_gen.sv ====
/* testbench clock and reset source
   free running clock, reset held high for the first few rising edges */

`default_nettype none

module dir_clk_gen #(
  parameter int period_p = 100,
  parameter int reset_cycles_p = 2
) (
  output logic clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

  // release on a rising edge so the DUT sees clean reset cycles
  initial begin
    reset_o <= 1'b1;
    repeat (reset_cycles_p) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== dir_tb.sv ====
/* coherence directory segment testbench
   replays the request table from the data file and checks sharers and entry results */

`default_nettype none

module dir_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_lce_lp = 4;
  localparam int tag_sets_lp = 64;
  localparam int rows_per_set_lp =
    (num_lce_lp + dir_pkg::tag_sets_per_row_c - 1) / dir_pkg::tag_sets_per_row_c;
  localparam int rows_lp = rows_per_set_lp * tag_sets_lp;
  localparam int way_width_lp = $bits(dir_pkg::way_t);
  localparam int state_width_lp = $bits(dir_pkg::coh_state_e);
  // bound on the wait for a read result
  localparam int result_wait_lp = rows_per_set_lp + 4;
  localparam int cycles_per_test_lp = 10;
  localparam int init_cycles_lp = 200;

  // one line of the data file
  typedef struct packed {
    logic [15:0] id;
    dir_pkg::dir_req_t req;
    logic [num_lce_lp-1:0] hits;
    dir_pkg::way_t [num_lce_lp-1:0] ways;
    dir_pkg::coh_state_e [num_lce_lp-1:0] states;
    dir_pkg::paddr_t addr;
  } test_vec_t;

  logic clk;
  logic reset;
  logic req_v;
  dir_pkg::dir_req_t req;
  logic busy;
  logic sharers_v;
  logic [num_lce_lp-1:0] sharers_hits;
  dir_pkg::way_t [num_lce_lp-1:0] sharers_ways;
  dir_pkg::coh_state_e [num_lce_lp-1:0] sharers_states;
  logic addr_v;
  dir_pkg::paddr_t addr;

  test_vec_t vecs[$];
  logic loaded;
  int error_count;
  int test_errors;
  int fail_tests;
  int cur_id;

  dir_clk_gen #(
    .period_p      (100),
    .reset_cycles_p(2)
  ) u_dir_clk_gen (
    .clk_o  (clk),
    .reset_o(reset)
  );

  dir_segment #(
    .num_lce_p (num_lce_lp),
    .tag_sets_p(tag_sets_lp)
  ) u_dir_segment (
    .clk_i           (clk),
    .reset_i         (reset),
    .req_v_i         (req_v),
    .req_i           (req),
    .busy_o          (busy),
    .sharers_v_o     (sharers_v),
    .sharers_hits_o  (sharers_hits),
    .sharers_ways_o  (sharers_ways),
    .sharers_states_o(sharers_states),
    .addr_v_o        (addr_v),
    .addr_o          (addr)
  );

  function automatic string cmd_name(input dir_pkg::dir_cmd_e c);
    case (c)
      dir_pkg::CMD_RDW: cmd_name = "RDW";
      dir_pkg::CMD_RDE: cmd_name = "RDE";
      dir_pkg::CMD_WDE: cmd_name = "WDE";
      dir_pkg::CMD_WDS: cmd_name = "WDS";
      dir_pkg::CMD_CLR: cmd_name = "CLR";
      default: cmd_name = "unknown";
    endcase
  endfunction

  task automatic load_vectors();
    int fd;
    int n;
    string line;
    logic [15:0] id;
    logic [2:0] cmd;
    dir_pkg::lce_t lce;
    dir_pkg::way_t way;
    dir_pkg::paddr_t req_addr;
    logic [2:0] state;
    logic [num_lce_lp-1:0] hits;
    logic [way_width_lp*num_lce_lp-1:0] ways;
    logic [state_width_lp*num_lce_lp-1:0] states;
    dir_pkg::paddr_t exp_addr;
    test_vec_t v;
    fd = $fopen("dir_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open dir_testdata.txt, no tests loaded");
      error_count++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        // lines starting with # describe the columns
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h", id, cmd, lce, way,
                      req_addr, state, hits, ways, states, exp_addr);
          if (n == 10) begin
            v.id = id;
            v.req.cmd = dir_pkg::dir_cmd_e'(cmd);
            v.req.lce = lce;
            v.req.way = way;
            v.req.addr = req_addr;
            v.req.state = dir_pkg::coh_state_e'(state);
            v.hits = hits;
            // slot 0 sits in the low bits of the packed columns
            for (int s = 0; s < num_lce_lp; s++) begin
              v.ways[s] = ways[way_width_lp*s +: way_width_lp];
              v.states[s] = dir_pkg::coh_state_e'(states[state_width_lp*s +: state_width_lp]);
            end
            v.addr = exp_addr;
            vecs.push_back(v);
          end else if (n > 0) begin
            $display("malformed line in dir_testdata.txt: %s", line);
            error_count++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_hits(input logic [num_lce_lp-1:0] got, input logic [num_lce_lp-1:0] exp);
    if (got !== exp) begin
      $display("ERR test %0d sharers_hits_o got %h exp %h", cur_id, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_ways(input dir_pkg::way_t [num_lce_lp-1:0] got,
                            input dir_pkg::way_t [num_lce_lp-1:0] exp);
    for (int s = 0; s < num_lce_lp; s++) begin
      if (got[s] !== exp[s]) begin
        $display("ERR test %0d sharers_ways_o[%0d] got %h exp %h", cur_id, s, got[s], exp[s]);
        test_errors++;
      end
    end
  endtask

  task automatic check_states(input dir_pkg::coh_state_e [num_lce_lp-1:0] got,
                              input dir_pkg::coh_state_e [num_lce_lp-1:0] exp);
    for (int s = 0; s < num_lce_lp; s++) begin
      if (got[s] !== exp[s]) begin
        $display("ERR test %0d sharers_states_o[%0d] got %h exp %h", cur_id, s, got[s], exp[s]);
        test_errors++;
      end
    end
  endtask

  task automatic check_addr(input dir_pkg::paddr_t got, input dir_pkg::paddr_t exp);
    if (got !== exp) begin
      $display("ERR test %0d addr_o got %h exp %h", cur_id, got, exp);
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    if (test_errors == 0) begin
      $display("test %0d %s ok", cur_id, name);
    end else begin
      $display("test %0d %s failed with %0d errors", cur_id, name, test_errors);
      fail_tests++;
    end
    error_count += test_errors;
  endtask

  // wait for busy low, drive on a rising edge, return at the acceptance edge
  task automatic send_request(input dir_pkg::dir_req_t r);
    @(negedge clk);
    while (busy) begin
      @(negedge clk);
    end
    @(posedge clk);
    req_v <= 1'b1;
    req <= r;
    @(posedge clk);
    req_v <= 1'b0;
    req <= '0;
  endtask

  task automatic wait_sharers(output logic seen);
    seen = 1'b0;
    for (int c = 0; c < result_wait_lp && !seen; c++) begin
      @(negedge clk);
      seen = sharers_v;
    end
  endtask

  task automatic check_init();
    int cycles;
    cur_id = 0;
    test_errors = 0;
    cycles = 0;
    @(negedge clk);
    while (reset) begin
      @(negedge clk);
    end
    if (busy !== 1'b1) begin
      $display("busy_o was not high right after reset");
      test_errors++;
    end
    if (sharers_v !== 1'b0 || addr_v !== 1'b0) begin
      $display("result valid flags were not low after reset");
      test_errors++;
    end
    // clearing pass visits every row once
    while (busy && cycles < rows_lp + 8) begin
      @(negedge clk);
      cycles++;
    end
    if (busy) begin
      $display("busy_o still high %0d cycles after reset", cycles);
      test_errors++;
    end
    report_test("reset clear");
  endtask

  task automatic run_test(input test_vec_t v);
    logic seen;
    cur_id = int'(v.id);
    test_errors = 0;
    send_request(v.req);
    case (v.req.cmd)
      dir_pkg::CMD_RDW, dir_pkg::CMD_RDE: begin
        wait_sharers(seen);
        if (!seen) begin
          $display("test %0d: sharers_v_o never rose after the read", cur_id);
          test_errors++;
        end else begin
          check_hits(sharers_hits, v.hits);
          check_ways(sharers_ways, v.ways);
          check_states(sharers_states, v.states);
          if (v.req.cmd == dir_pkg::CMD_RDE) begin
            if (addr_v !== 1'b1) begin
              $display("test %0d: addr_v_o stayed low after the entry read", cur_id);
              test_errors++;
            end else begin
              check_addr(addr, v.addr);
            end
          end else if (addr_v !== 1'b0) begin
            $display("test %0d: addr_v_o still high after the full read", cur_id);
            test_errors++;
          end
        end
      end
      default: begin
        // a write leaves the directory ready and drops both held results
        @(negedge clk);
        if (busy !== 1'b0) begin
          $display("test %0d: busy_o went high after the write", cur_id);
          test_errors++;
        end
        @(negedge clk);
        if (sharers_v !== 1'b0) begin
          $display("test %0d: sharers_v_o still high after the write", cur_id);
          test_errors++;
        end
        if (addr_v !== 1'b0) begin
          $display("test %0d: addr_v_o still high after the write", cur_id);
          test_errors++;
        end
      end
    endcase
    report_test(cmd_name(v.req.cmd));
  endtask

  initial begin
    req_v <= 1'b0;
    req <= '0;
    loaded = 1'b0;
    error_count = 0;
    fail_tests = 0;
    load_vectors();
    loaded = 1'b1;
    check_init();
    foreach (vecs[i]) begin
      run_test(vecs[i]);
    end
    $display("%0d tests, %0d failed, %0d errors", vecs.size() + 1, fail_tests, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog sized from the table length
  initial begin
    int limit;
    wait (loaded);
    limit = vecs.size() * cycles_per_test_lp + init_cycles_lp;
    repeat (limit) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles", limit);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dir_testdata.txt ====
# id(decimal) cmd lce way addr state | expected hits ways states addr (hex, slot 0 in low bits)
# cmd 0 RDW 1 RDE 2 WDE 3 WDS 4 CLR | state 0 I 1 S 2 E 3 F 4 O 5 M
1 0 0 0 ABCDE140 0 0 000 000 00000000
2 0 0 0 00000FC0 0 0 000 000 00000000
3 2 1 5 ABCDE140 5 0 000 000 00000000
4 1 1 5 ABCDE140 0 1 005 005 ABCDE000
5 1 1 5 12345140 0 0 005 005 ABCDE000
6 2 0 3 ABCDE140 1 0 000 000 00000000
7 2 0 6 ABCDE140 2 0 000 000 00000000
8 2 3 2 ABCDE140 4 0 000 000 00000000
9 2 3 1 12345140 5 0 000 000 00000000
10 2 2 0 ABCDE240 1 0 000 000 00000000
11 0 0 0 ABCDE140 0 B 42B 829 00000000
12 0 0 0 ABCDE240 0 4 000 040 00000000
13 0 0 0 12345140 0 8 200 A00 00000000
14 3 1 5 00000140 3 0 000 000 00000000
15 1 1 5 ABCDE140 0 1 005 003 ABCDE000
16 3 0 3 ABCDE140 0 0 000 000 00000000
17 0 0 0 ABCDE140 0 B 42E 81A 00000000
18 3 0 6 ABCDE140 0 0 000 000 00000000
19 0 0 0 ABCDE140 0 A 428 818 00000000
20 1 0 3 ABCDE140 0 0 003 000 ABCDE000
21 2 2 4 ABCDE140 5 0 000 000 00000000
22 0 0 0 ABCDE140 0 E 528 958 00000000
23 4 2 0 ABCDE140 0 0 000 000 00000000
24 0 0 0 ABCDE140 0 2 028 018 00000000
25 0 0 0 12345140 0 0 000 000 00000000
26 0 0 0 ABCDE240 0 4 000 040 00000000
27 2 0 7 ABCDE140 4 0 000 000 00000000
28 0 0 0 ABCDE140 0 3 02F 01C 00000000
29 1 1 5 ABCDE140 0 1 005 003 ABCDE000
30 1 3 1 12345140 0 0 001 000 00000000
31 2 3 7 FFFFFFC0 2 0 000 000 00000000
32 0 0 0 FFFFFFC0 0 8 E00 400 00000000
33 1 3 7 FFFFFFC0 0 1 007 002 FFFFF000

// ==== dir_segment.f ====
dir_pkg.sv
dir_ram.sv
dir_tag_check.sv
dir_sharers.sv
dir_ctrl.sv
dir_segment.sv
dir_clk_gen.sv
dir_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := dir_tb
FILELIST  := dir_segment.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) dir_testdata.txt
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)
